// File: common/noc_dma_pkg.sv
package noc_dma_pkg;

  // flit width is fixed for the whole network, one flit per ram word
  localparam int FLIT_W = 32;
  localparam int ADDR_W = 16;
  localparam int SIZE_W = 16;

  // one network flit, also one scratchpad word
  typedef logic [FLIT_W-1:0] flit_t;

  // word address, only the low bits below RAM_WORDS select a word
  typedef logic [ADDR_W-1:0] word_addr_t;

  // payload length in flits, header and size flits not counted
  typedef logic [SIZE_W-1:0] pkt_size_t;

  // send command from the host, stable while send_req is high
  typedef struct packed {
    // header flit value
    flit_t      dest;
    // first payload word
    word_addr_t addr;
    // payload flits to send
    pkt_size_t  size;
  } send_cmd_t;

  // one access on the shared dma port of the scratchpad
  typedef struct packed {
    logic       en;
    // write when set, read otherwise
    logic       we;
    word_addr_t addr;
    flit_t      wdata;
  } mem_req_t;

endpackage

// File: ddma/ddma.sv
`timescale 1ns/1ps

module ddma #(
  parameter int RAM_WORDS        = 256,
  parameter int INTERLEAVE_GRAIN = 4
) (
  input  logic                       clock,
  input  logic                       reset,
  input  noc_dma_pkg::send_cmd_t     send_cmd_i,
  input  logic                       send_req_i,
  output logic                       send_ack_o,
  output noc_dma_pkg::pkt_size_t     recv_size_o,
  output logic                       recv_size_valid_o,
  input  noc_dma_pkg::word_addr_t    recv_addr_i,
  input  logic                       recv_go_i,
  output logic                       recv_done_o,
  output noc_dma_pkg::flit_t         out_flit_o,
  output logic                       out_valid_o,
  input  logic                       out_credit_i,
  input  noc_dma_pkg::flit_t         in_flit_i,
  input  logic                       in_valid_i,
  output logic                       in_credit_o,
  output noc_dma_pkg::mem_req_t      mem_req_o,
  input  noc_dma_pkg::flit_t         mem_rdata_i
);
  import noc_dma_pkg::*;

  localparam int CW = $clog2(INTERLEAVE_GRAIN + 1);

  // one-hot token, the two handover states are dead cycles
  typedef enum logic [3:0] {
    TOKEN_SEND         = 4'b0001,
    TOKEN_RECV         = 4'b0010,
    TOKEN_SEND_TO_RECV = 4'b0100,
    TOKEN_RECV_TO_SEND = 4'b1000
  } token_t;

  token_t          token;
  logic [CW-1:0]   grain_cnt;
  logic            grain_done;
  logic            send_grant;
  logic            recv_grant;
  logic            send_pending;
  logic            recv_pending;
  mem_req_t        send_mem_req;
  mem_req_t        recv_mem_req;

  assign grain_done = (grain_cnt == '0);
  assign send_grant = (token == TOKEN_SEND);
  assign recv_grant = (token == TOKEN_RECV);

  // turn ends on grain expiry, or early when the holder is idle,
  // but only if the other engine actually wants the port
  always_ff @(posedge clock) begin
    if (!reset) begin
      token     <= TOKEN_SEND;
      grain_cnt <= CW'(INTERLEAVE_GRAIN - 1);
    end else begin
      if (!grain_done) begin
        grain_cnt <= grain_cnt - 1'b1;
      end
      case (token)
        TOKEN_SEND: begin
          if (recv_pending && (grain_done || !send_pending)) begin
            token <= TOKEN_SEND_TO_RECV;
          end
        end
        TOKEN_RECV: begin
          if (send_pending && (grain_done || !recv_pending)) begin
            token <= TOKEN_RECV_TO_SEND;
          end
        end
        TOKEN_SEND_TO_RECV: begin
          token     <= TOKEN_RECV;
          grain_cnt <= CW'(INTERLEAVE_GRAIN - 1);
        end
        default: begin
          token     <= TOKEN_SEND;
          grain_cnt <= CW'(INTERLEAVE_GRAIN - 1);
        end
      endcase
    end
  end

  // nobody owns the port in a dead cycle, so an in-flight read
  // returns before the other engine can touch the ram
  always_comb begin
    case (token)
      TOKEN_SEND: mem_req_o = send_mem_req;
      TOKEN_RECV: mem_req_o = recv_mem_req;
      default:    mem_req_o = '0;
    endcase
  end

  ddma_send #(
    .RAM_WORDS (RAM_WORDS)
  ) u_send (
    .clock        (clock),
    .reset        (reset),
    .send_cmd_i   (send_cmd_i),
    .send_req_i   (send_req_i),
    .send_ack_o   (send_ack_o),
    .out_flit_o   (out_flit_o),
    .out_valid_o  (out_valid_o),
    .out_credit_i (out_credit_i),
    .grant_i      (send_grant),
    .mem_req_o    (send_mem_req),
    .mem_rdata_i  (mem_rdata_i),
    .pending_o    (send_pending)
  );

  ddma_recv #(
    .RAM_WORDS (RAM_WORDS)
  ) u_recv (
    .clock             (clock),
    .reset             (reset),
    .in_flit_i         (in_flit_i),
    .in_valid_i        (in_valid_i),
    .in_credit_o       (in_credit_o),
    .recv_size_o       (recv_size_o),
    .recv_size_valid_o (recv_size_valid_o),
    .recv_addr_i       (recv_addr_i),
    .recv_go_i         (recv_go_i),
    .recv_done_o       (recv_done_o),
    .grant_i           (recv_grant),
    .mem_req_o         (recv_mem_req),
    .pending_o         (recv_pending)
  );

endmodule

// File: ddma/ddma_recv.sv
`timescale 1ns/1ps

module ddma_recv #(
  parameter int RAM_WORDS = 256
) (
  input  logic                       clock,
  input  logic                       reset,
  input  noc_dma_pkg::flit_t         in_flit_i,
  input  logic                       in_valid_i,
  output logic                       in_credit_o,
  output noc_dma_pkg::pkt_size_t     recv_size_o,
  output logic                       recv_size_valid_o,
  input  noc_dma_pkg::word_addr_t    recv_addr_i,
  input  logic                       recv_go_i,
  output logic                       recv_done_o,
  input  logic                       grant_i,
  output noc_dma_pkg::mem_req_t      mem_req_o,
  output logic                       pending_o
);
  import noc_dma_pkg::*;

  localparam word_addr_t ADDR_MASK = word_addr_t'(RAM_WORDS - 1);

  typedef enum logic [2:0] {
    R_HEADER,
    R_SIZE,
    R_ADDR,
    R_PAYLOAD,
    R_DONE
  } recv_state_t;

  recv_state_t state;
  word_addr_t  wr_addr;
  // payload flits still expected
  pkt_size_t   left;
  logic        can_take;
  logic        wr_fire;

  // header and size need no ram, payload needs the token
  assign can_take = (state == R_HEADER) || (state == R_SIZE) ||
                    ((state == R_PAYLOAD) && grant_i);

  // credit only in a cycle where a flit is actually taken
  assign in_credit_o = in_valid_i && can_take;
  assign wr_fire     = in_credit_o && (state == R_PAYLOAD);

  // a flit waiting at the port is work for the arbiter
  assign pending_o = (state == R_PAYLOAD) && in_valid_i;

  // size and done double as the receive interrupts
  assign recv_size_valid_o = (state == R_ADDR);
  assign recv_done_o       = (state == R_DONE);

  // payload goes to ram in the cycle it is accepted
  always_comb begin
    mem_req_o       = '0;
    mem_req_o.en    = wr_fire;
    mem_req_o.we    = wr_fire;
    mem_req_o.addr  = wr_addr;
    mem_req_o.wdata = in_flit_i;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state   <= R_HEADER;
      wr_addr <= '0;
      left    <= '0;
    end else begin
      case (state)
        R_HEADER: begin
          // destination is not checked, header just dropped
          if (in_credit_o) begin
            state <= R_SIZE;
          end
        end
        R_SIZE: begin
          if (in_credit_o) begin
            state <= R_ADDR;
          end
        end
        R_ADDR: begin
          // host answers the size with a target address
          if (recv_go_i) begin
            wr_addr <= recv_addr_i & ADDR_MASK;
            left    <= recv_size_o;
            if (recv_size_o == '0) begin
              state <= R_DONE;
            end else begin
              state <= R_PAYLOAD;
            end
          end
        end
        R_PAYLOAD: begin
          if (wr_fire) begin
            wr_addr <= (wr_addr + 1'b1) & ADDR_MASK;
            left    <= left - 1'b1;
            // last write issued this cycle
            if (left == pkt_size_t'(1)) begin
              state <= R_DONE;
            end
          end
        end
        default: begin
          // second round of the handshake closes on go low
          if (!recv_go_i) begin
            state <= R_HEADER;
          end
        end
      endcase
    end
  end

  // size register holds for the host until the next packet
  always_ff @(posedge clock) begin
    if ((state == R_SIZE) && in_credit_o) begin
      recv_size_o <= pkt_size_t'(in_flit_i);
    end
  end

endmodule

// File: ddma/ddma_send.sv
`timescale 1ns/1ps

module ddma_send #(
  parameter int RAM_WORDS = 256
) (
  input  logic                       clock,
  input  logic                       reset,
  input  noc_dma_pkg::send_cmd_t     send_cmd_i,
  input  logic                       send_req_i,
  output logic                       send_ack_o,
  output noc_dma_pkg::flit_t         out_flit_o,
  output logic                       out_valid_o,
  input  logic                       out_credit_i,
  input  logic                       grant_i,
  output noc_dma_pkg::mem_req_t      mem_req_o,
  input  noc_dma_pkg::flit_t         mem_rdata_i,
  output logic                       pending_o
);
  import noc_dma_pkg::*;

  localparam word_addr_t ADDR_MASK = word_addr_t'(RAM_WORDS - 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HEADER,
    S_SIZE,
    S_PAYLOAD,
    S_ACK
  } send_state_t;

  send_state_t state;
  flit_t       dest_q;
  word_addr_t  rd_addr;
  // reads still to issue, and payload flits still to load
  pkt_size_t   rd_left;
  pkt_size_t   tx_left;
  // single prefetch slot
  flit_t       buf_data;
  logic        buf_valid;
  logic        in_flight;
  logic        active;
  logic        out_free;
  logic        buf_move;
  logic        rd_go;

  assign active   = (state == S_HEADER) || (state == S_SIZE) || (state == S_PAYLOAD);
  // output register can take a new flit this cycle
  assign out_free = !out_valid_o || out_credit_i;
  assign buf_move = (state == S_PAYLOAD) && buf_valid && out_free;
  // prefetch may start during header and size
  assign rd_go    = active && grant_i && (rd_left != '0) && !in_flight &&
                    (!buf_valid || buf_move);

  // a full slot means nothing to do with the port
  assign pending_o  = active && (rd_left != '0) && !buf_valid;
  // ack doubles as the send interrupt
  assign send_ack_o = (state == S_ACK);

  always_comb begin
    mem_req_o      = '0;
    mem_req_o.en   = rd_go;
    mem_req_o.addr = rd_addr;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state       <= S_IDLE;
      out_valid_o <= 1'b0;
      buf_valid   <= 1'b0;
      in_flight   <= 1'b0;
      rd_addr     <= '0;
      rd_left     <= '0;
      tx_left     <= '0;
    end else begin
      // flit leaves on credit
      if (out_valid_o && out_credit_i) begin
        out_valid_o <= 1'b0;
      end
      if (buf_move) begin
        buf_valid   <= 1'b0;
        out_valid_o <= 1'b1;
        tx_left     <= tx_left - 1'b1;
      end
      in_flight <= rd_go;
      // read data lands in the slot, which is empty by construction
      if (in_flight) begin
        buf_valid <= 1'b1;
      end
      if (rd_go) begin
        rd_left <= rd_left - 1'b1;
        rd_addr <= (rd_addr + 1'b1) & ADDR_MASK;
      end
      case (state)
        S_IDLE: begin
          if (send_req_i) begin
            rd_addr <= send_cmd_i.addr & ADDR_MASK;
            rd_left <= send_cmd_i.size;
            tx_left <= send_cmd_i.size;
            state   <= S_HEADER;
          end
        end
        S_HEADER: begin
          if (out_free) begin
            out_valid_o <= 1'b1;
            state       <= S_SIZE;
          end
        end
        S_SIZE: begin
          if (out_free) begin
            out_valid_o <= 1'b1;
            state       <= S_PAYLOAD;
          end
        end
        S_PAYLOAD: begin
          // wait until the last flit has really left
          if ((tx_left == '0) && !out_valid_o) begin
            state <= S_ACK;
          end
        end
        default: begin
          if (!send_req_i) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if ((state == S_IDLE) && send_req_i) begin
      dest_q <= send_cmd_i.dest;
    end
    if (in_flight) begin
      buf_data <= mem_rdata_i;
    end
    if ((state == S_HEADER) && out_free) begin
      out_flit_o <= dest_q;
    end else if ((state == S_SIZE) && out_free) begin
      // tx_left still holds the full size here
      out_flit_o <= flit_t'(tx_left);
    end else if (buf_move) begin
      out_flit_o <= buf_data;
    end
  end

endmodule

// File: list.f
common/noc_dma_pkg.sv
logic/scratch_ram.sv
ddma/ddma_send.sv
ddma/ddma_recv.sv
ddma/ddma.sv
logic/dma_tile.sv
sim/tb_clock_gen.sv
sim/tb_dma_tile.sv

// File: logic/dma_tile.sv
`timescale 1ns/1ps

module dma_tile #(
  parameter int RAM_WORDS        = 256,
  parameter int INTERLEAVE_GRAIN = 4
) (
  input  logic                       clock,
  input  logic                       reset,
  input  noc_dma_pkg::send_cmd_t     send_cmd_i,
  input  logic                       send_req_i,
  output logic                       send_ack_o,
  output noc_dma_pkg::pkt_size_t     recv_size_o,
  output logic                       recv_size_valid_o,
  input  noc_dma_pkg::word_addr_t    recv_addr_i,
  input  logic                       recv_go_i,
  output logic                       recv_done_o,
  output noc_dma_pkg::flit_t         out_flit_o,
  output logic                       out_valid_o,
  input  logic                       out_credit_i,
  input  noc_dma_pkg::flit_t         in_flit_i,
  input  logic                       in_valid_i,
  output logic                       in_credit_o,
  input  logic                       host_en_i,
  input  logic                       host_we_i,
  input  noc_dma_pkg::word_addr_t    host_addr_i,
  input  noc_dma_pkg::flit_t         host_wdata_i,
  output noc_dma_pkg::flit_t         host_rdata_o
);
  import noc_dma_pkg::*;

  // shared dma port between the engines and the scratchpad
  mem_req_t dma_req;
  flit_t    dma_rdata;

  scratch_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_scratch_ram (
    .clock        (clock),
    .dma_req_i    (dma_req),
    .dma_rdata_o  (dma_rdata),
    .host_en_i    (host_en_i),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_rdata_o (host_rdata_o)
  );

  ddma #(
    .RAM_WORDS        (RAM_WORDS),
    .INTERLEAVE_GRAIN (INTERLEAVE_GRAIN)
  ) u_ddma (
    .clock             (clock),
    .reset             (reset),
    .send_cmd_i        (send_cmd_i),
    .send_req_i        (send_req_i),
    .send_ack_o        (send_ack_o),
    .recv_size_o       (recv_size_o),
    .recv_size_valid_o (recv_size_valid_o),
    .recv_addr_i       (recv_addr_i),
    .recv_go_i         (recv_go_i),
    .recv_done_o       (recv_done_o),
    .out_flit_o        (out_flit_o),
    .out_valid_o       (out_valid_o),
    .out_credit_i      (out_credit_i),
    .in_flit_i         (in_flit_i),
    .in_valid_i        (in_valid_i),
    .in_credit_o       (in_credit_o),
    .mem_req_o         (dma_req),
    .mem_rdata_i       (dma_rdata)
  );

endmodule

// File: logic/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic                       clock,
  input  noc_dma_pkg::mem_req_t      dma_req_i,
  output noc_dma_pkg::flit_t         dma_rdata_o,
  input  logic                       host_en_i,
  input  logic                       host_we_i,
  input  noc_dma_pkg::word_addr_t    host_addr_i,
  input  noc_dma_pkg::flit_t         host_wdata_i,
  output noc_dma_pkg::flit_t         host_rdata_o
);
  import noc_dma_pkg::*;

  localparam int AW = $clog2(RAM_WORDS);

  flit_t           mem [RAM_WORDS];
  logic [AW-1:0]   dma_idx;
  logic [AW-1:0]   host_idx;

  // low address bits only, so both ports wrap at RAM_WORDS
  assign dma_idx  = dma_req_i.addr[AW-1:0];
  assign host_idx = host_addr_i[AW-1:0];

  always_ff @(posedge clock) begin
    if (host_en_i && host_we_i) begin
      mem[host_idx] <= host_wdata_i;
    end
    // dma write comes last so it wins on a same-word collision
    if (dma_req_i.en && dma_req_i.we) begin
      mem[dma_idx] <= dma_req_i.wdata;
    end
    // read-first, data one cycle after the request
    if (host_en_i) begin
      host_rdata_o <= mem[host_idx];
    end
    if (dma_req_i.en) begin
      dma_rdata_o <= mem[dma_idx];
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the dma tile testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_dma_tile -f list.f -o tb_dma_tile \
  && ./obj_dir/tb_dma_tile | tee /dev/stderr | grep -q "Verification passed" \
  && echo "simulation run ok" \
  || { echo "simulation run reported a failure"; exit 1; }

// File: sim/dma_golden.txt
// kind (1 send, 2 receive, 3 both at once), header dest, send address, receive address,
// payload size, back-pressure flag; next line holds eight payload words
1 0000a001 0010 0000 4 0
11111111 22222222 33333333 44444444 0 0 0 0
1 0000a001 0010 0000 4 1
11111111 22222222 33333333 44444444 0 0 0 0
1 0000a002 00fa 0000 8 1
c0de0001 c0de0002 c0de0003 c0de0004 c0de0005 c0de0006 c0de0007 c0de0008
2 0000b001 0000 0040 5 1
0badf00d 12345678 9abcdef0 0f0f0f0f f0f0f0f0 0 0 0
2 0000b002 0000 00fc 8 1
a5a50001 a5a50002 a5a50003 a5a50004 a5a50005 a5a50006 a5a50007 a5a50008
3 0000a003 0080 00c0 8 1
10000001 20000002 30000003 40000004 50000005 60000006 70000007 80000008
3 0000a004 0090 00d0 6 0
01020304 05060708 090a0b0c 0d0e0f10 11121314 15161718 0 0
2 0000b003 0000 0020 0 0
0 0 0 0 0 0 0 0
1 0000a005 0030 0000 1 1
deadbeef 0 0 0 0 0 0 0

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic clock_o,
  output logic reset_o
);

  // 40 ns period, first rising edge at 20 ns
  initial begin
    clock_o = 1'b0;
    forever #(HALF_PERIOD) clock_o = ~clock_o;
  end

  // active low reset, released on a rising edge
  initial begin
    reset_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock_o);
    reset_o <= 1'b1;
  end

endmodule

// File: sim/tb_dma_tile.sv
`timescale 1ns/1ps

module tb_dma_tile;
  import noc_dma_pkg::*;

  localparam int RAM_WORDS = 256;
  localparam int GRAIN     = 4;
  // words per golden record
  localparam int REC_W     = 14;
  localparam int MAX_REC   = 16;
  // cycles a single wait may take
  localparam int LIMIT     = 4000;

  logic        clock;
  logic        reset;
  send_cmd_t   send_cmd;
  logic        send_req;
  logic        send_ack;
  pkt_size_t   recv_size;
  logic        recv_size_valid;
  word_addr_t  recv_addr;
  logic        recv_go;
  logic        recv_done;
  flit_t       out_flit;
  logic        out_valid;
  logic        out_credit = 1'b0;
  flit_t       in_flit;
  logic        in_valid;
  logic        in_credit;
  logic        host_en;
  logic        host_we;
  word_addr_t  host_addr;
  flit_t       host_wdata;
  flit_t       host_rdata;

  logic [31:0] golden [MAX_REC*REC_W];
  flit_t       send_exp [8];
  flit_t       recv_exp [8];
  // every flit that left on the network port
  flit_t       out_q [$];
  logic        bp_out;
  logic        bp_in;
  // router may present an input flit this cycle
  logic        valid_slot = 1'b1;
  logic [31:0] rng = 32'hc945192e;
  int          errors;
  int          tests;
  int          failed;

  tb_clock_gen u_clock_gen (
    .clock_o (clock),
    .reset_o (reset)
  );

  dma_tile #(
    .RAM_WORDS        (RAM_WORDS),
    .INTERLEAVE_GRAIN (GRAIN)
  ) u_dma_tile (
    .clock             (clock),
    .reset             (reset),
    .send_cmd_i        (send_cmd),
    .send_req_i        (send_req),
    .send_ack_o        (send_ack),
    .recv_size_o       (recv_size),
    .recv_size_valid_o (recv_size_valid),
    .recv_addr_i       (recv_addr),
    .recv_go_i         (recv_go),
    .recv_done_o       (recv_done),
    .out_flit_o        (out_flit),
    .out_valid_o       (out_valid),
    .out_credit_i      (out_credit),
    .in_flit_i         (in_flit),
    .in_valid_i        (in_valid),
    .in_credit_o       (in_credit),
    .host_en_i         (host_en),
    .host_we_i         (host_we),
    .host_addr_i       (host_addr),
    .host_wdata_i      (host_wdata),
    .host_rdata_o      (host_rdata)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic string kind_name(input int kind);
    case (kind)
      1: return "send";
      2: return "receive";
      3: return "send and receive";
      default: return "unknown";
    endcase
  endfunction

  // about one cycle in four loses credit or the input slot under back-pressure
  always @(posedge clock) begin
    rng = xorshift(rng);
    out_credit <= !bp_out || (rng[1:0] != 2'b00);
    valid_slot <= !bp_in || (rng[3:2] != 2'b00);
  end

  // network sink, sampled mid-cycle where valid and credit are settled
  always @(negedge clock) begin
    if (reset && out_valid && out_credit) begin
      out_q.push_back(out_flit);
    end
  end

  task automatic abort_run(input string msg);
    $display("Timeout: %s", msg);
    $display("Verification failed");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp) else begin
      $display("Error: time %0d ns, %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_idle();
    check_value("out_valid_o", 32'h0, 32'(out_valid));
    check_value("in_credit_o", 32'h0, 32'(in_credit));
    check_value("send_ack_o", 32'h0, 32'(send_ack));
    check_value("recv_size_valid_o", 32'h0, 32'(recv_size_valid));
    check_value("recv_done_o", 32'h0, 32'(recv_done));
  endtask

  task automatic report_test(input int num, input string name, input int err_start);
    tests++;
    if (errors == err_start) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      failed++;
      $display("test %0d %s: %0d errors", num, name, errors - err_start);
    end
  endtask

  task automatic host_write(input word_addr_t a, input flit_t d);
    @(posedge clock);
    host_en    <= 1'b1;
    host_we    <= 1'b1;
    host_addr  <= a;
    host_wdata <= d;
    @(posedge clock);
    host_en <= 1'b0;
    host_we <= 1'b0;
  endtask

  // data comes one cycle after the request
  task automatic host_read(input word_addr_t a, output flit_t d);
    @(posedge clock);
    host_en   <= 1'b1;
    host_we   <= 1'b0;
    host_addr <= a;
    @(posedge clock);
    host_en <= 1'b0;
    @(negedge clock);
    d = host_rdata;
  endtask

  task automatic preload(input word_addr_t a, input int n);
    for (int i = 0; i < n; i++) begin
      host_write(word_addr_t'((int'(a) + i) % RAM_WORDS), send_exp[i]);
    end
  endtask

  task automatic verify_ram(input word_addr_t a, input int n);
    flit_t d;
    for (int i = 0; i < n; i++) begin
      host_read(word_addr_t'((int'(a) + i) % RAM_WORDS), d);
      check_value("host_rdata_o", recv_exp[i], d);
    end
  endtask

  // router side, the flit holds until the dut gives credit
  task automatic inject_flit(input flit_t f);
    int cnt;
    cnt = 0;
    @(posedge clock);
    while (!valid_slot) begin
      cnt++;
      if (cnt > LIMIT) begin
        abort_run("no free slot to present an input flit");
      end
      @(posedge clock);
    end
    in_valid <= 1'b1;
    in_flit  <= f;
    cnt = 0;
    @(negedge clock);
    while (!in_credit) begin
      cnt++;
      if (cnt > LIMIT) begin
        abort_run("in_credit_o never rose for a waiting input flit");
      end
      @(negedge clock);
    end
    // flit transfers on this edge
    @(posedge clock);
    in_valid <= 1'b0;
  endtask

  task automatic send_packet(input flit_t dest, input word_addr_t a, input int n);
    int    cnt;
    int    first;
    flit_t exp;
    first = out_q.size();
    @(posedge clock);
    send_cmd.dest <= dest;
    send_cmd.addr <= a;
    send_cmd.size <= pkt_size_t'(n);
    send_req      <= 1'b1;
    cnt = 0;
    @(negedge clock);
    while (!send_ack) begin
      cnt++;
      if (cnt > LIMIT) begin
        abort_run("send_ack_o never rose");
      end
      @(negedge clock);
    end
    // ack only once header, size and all payload flits have left
    assert (out_q.size() - first == n + 2) else begin
      $display("Error: time %0d ns, send_ack_o rose after %0d flits instead of %0d",
               $time, out_q.size() - first, n + 2);
      errors++;
    end
    @(posedge clock);
    send_req <= 1'b0;
    // ack holds until the dut has seen the request drop
    @(negedge clock);
    check_value("send_ack_o", 32'h1, 32'(send_ack));
    cnt = 0;
    while (send_ack) begin
      cnt++;
      if (cnt > LIMIT) begin
        abort_run("send_ack_o stayed high after send_req_i dropped");
      end
      @(negedge clock);
    end
    for (int i = 0; (i < n + 2) && (first + i < out_q.size()); i++) begin
      if (i == 0) begin
        exp = dest;
      end else if (i == 1) begin
        exp = flit_t'(n);
      end else begin
        exp = send_exp[i - 2];
      end
      check_value("out_flit_o", exp, out_q[first + i]);
    end
  endtask

  task automatic recv_packet(input flit_t hdr, input word_addr_t a, input int n);
    int cnt;
    inject_flit(hdr);
    inject_flit(flit_t'(n));
    cnt = 0;
    @(negedge clock);
    while (!recv_size_valid) begin
      cnt++;
      if (cnt > LIMIT) begin
        abort_run("recv_size_valid_o never rose after the size flit");
      end
      @(negedge clock);
    end
    check_value("recv_size_o", 32'(n), 32'(recv_size));
    // first round closes with go, dut latches the address
    @(posedge clock);
    recv_addr <= a;
    recv_go   <= 1'b1;
    cnt = 0;
    @(negedge clock);
    while (recv_size_valid) begin
      cnt++;
      if (cnt > LIMIT) begin
        abort_run("recv_size_valid_o stayed high after recv_go_i rose");
      end
      @(negedge clock);
    end
    for (int i = 0; i < n; i++) begin
      inject_flit(recv_exp[i]);
    end
    cnt = 0;
    @(negedge clock);
    while (!recv_done) begin
      cnt++;
      if (cnt > LIMIT) begin
        abort_run("recv_done_o never rose after the payload");
      end
      @(negedge clock);
    end
    @(posedge clock);
    recv_go <= 1'b0;
    cnt = 0;
    @(negedge clock);
    while (recv_done) begin
      cnt++;
      if (cnt > LIMIT) begin
        abort_run("recv_done_o stayed high after recv_go_i dropped");
      end
      @(negedge clock);
    end
  endtask

  initial begin
    int         n;
    int         base;
    int         kind;
    int         size_n;
    int         err_before;
    flit_t      dest;
    word_addr_t saddr;
    word_addr_t raddr;
    flit_t      d;
    send_cmd   = '0;
    send_req   = 1'b0;
    recv_addr  = '0;
    recv_go    = 1'b0;
    in_flit    = '0;
    in_valid   = 1'b0;
    host_en    = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    bp_out     = 1'b0;
    bp_in      = 1'b0;
    for (int i = 0; i < MAX_REC*REC_W; i++) begin
      golden[i] = '0;
    end
    $readmemh("sim/dma_golden.txt", golden);

    // outputs stay low through reset and one cycle after
    err_before = errors;
    n = 0;
    // first rising edge loads the synchronous reset
    @(posedge clock);
    @(negedge clock);
    while (!reset) begin
      check_idle();
      n++;
      if (n > 50) begin
        abort_run("reset was never released");
      end
      @(negedge clock);
    end
    check_idle();
    report_test(0, "idle after reset", err_before);

    for (int r = 0; r < MAX_REC; r++) begin
      base = r * REC_W;
      kind = int'(golden[base]);
      // a zero kind ends the list
      if (kind == 0) begin
        break;
      end
      dest   = golden[base + 1];
      saddr  = word_addr_t'(golden[base + 2]);
      raddr  = word_addr_t'(golden[base + 3]);
      size_n = int'(golden[base + 4]);
      for (int i = 0; i < 8; i++) begin
        send_exp[i] = golden[base + 6 + i];
        // the concurrent receive carries the inverted words
        recv_exp[i] = (kind == 3) ? ~golden[base + 6 + i] : golden[base + 6 + i];
      end
      err_before = errors;
      bp_out <= golden[base + 5][0];
      bp_in  <= golden[base + 5][0];
      assert ((kind >= 1) && (kind <= 3)) else begin
        $display("Error: record %0d has an unknown test kind %0d", r + 1, kind);
        errors++;
      end
      case (kind)
        1: begin
          preload(saddr, size_n);
          send_packet(dest, saddr, size_n);
        end
        2: begin
          if (size_n == 0) begin
            // marker must survive an empty packet
            host_write(raddr, {16'h5a5a, raddr});
            recv_packet(dest, raddr, size_n);
            host_read(raddr, d);
            check_value("host_rdata_o", {16'h5a5a, raddr}, d);
          end else begin
            recv_packet(dest, raddr, size_n);
            verify_ram(raddr, size_n);
          end
        end
        3: begin
          preload(saddr, size_n);
          // both engines compete for the ram port
          fork
            send_packet(dest, saddr, size_n);
            recv_packet(dest, raddr, size_n);
          join
          verify_ram(raddr, size_n);
        end
        default: begin
          // already counted above
        end
      endcase
      report_test(r + 1, kind_name(kind), err_before);
    end

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
